// File: Makefile
VERILATOR ?= verilator
TOP       ?= cpuTb
FILELIST  ?= cpuTop.f
OBJ_DIR   ?= obj_dir
LOG       ?= sim.log
FAIL_TEXT ?= FAIL: see errors above
VFLAGS    ?= --binary --timing --assert --timescale 1ns/100ps -Wno-fatal

SOURCES := $(shell grep -v '^+' $(FILELIST)) design/cpu_config.svh
SIM_BIN := $(OBJ_DIR)/V$(TOP)

.PHONY: all compile run clean

all: run

compile: $(SIM_BIN)

$(SIM_BIN): $(FILELIST) $(SOURCES)
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(OBJ_DIR) -f $(FILELIST)

# The log is searched for the fail line; a crash or assertion stop also fails.
run: compile
	@./$(SIM_BIN) > $(LOG) 2>&1; status=$$?; cat $(LOG); \
	if grep -q "$(FAIL_TEXT)" $(LOG) || [ $$status -ne 0 ]; then \
		echo "Simulation failed, see $(LOG)."; exit 1; \
	fi

clean:
	rm -rf $(OBJ_DIR) $(LOG)

// File: cpuTop.f
+incdir+design
design/cpuPkg.sv
design/cpuMemory.sv
design/cpuDecode.sv
design/cpuExecute.sv
design/cpuResult.sv
design/cpuTop.sv
tests/cpuTop_sva.sv
tests/cpuTb.sv

// File: design/cpuDecode.sv
`timescale 1ns/100ps
`include "cpu_config.svh"

module cpuDecode (
	input  logic                 clk,
	input  logic                 nRst,
	input  logic                 run,
	input  cpuPkg::byte_t        rdata,
	input  cpuPkg::byte_t        storeData,
	input  logic                 halted,
	input  cpuPkg::execResult_t  exec,
	output cpuPkg::memReq_t      memReq,
	output cpuPkg::decodedOp_t   op,
	output logic                 busy
);

	cpuPkg::decodeState_t state;
	cpuPkg::decodeState_t stateNext;
	cpuPkg::addr_t        pc;
	cpuPkg::opcode_t      opcode;
	cpuPkg::byte_t        operand;
	logic                 isStore;
	logic                 isLoad;

	assign isStore = (opcode == cpuPkg::STA);

	// Instructions that read their memory operand.
	always_comb begin
		case (opcode)
			cpuPkg::LDA,
			cpuPkg::ADD,
			cpuPkg::SUB,
			cpuPkg::AND,
			cpuPkg::OR,
			cpuPkg::XOR: isLoad = 1'b1;
			default:     isLoad = 1'b0;
		endcase
	end

	always_comb begin
		stateNext = state;
		case (state)
			cpuPkg::IDLE: begin
				if (run) begin
					stateNext = cpuPkg::FETCH;
				end
			end
			cpuPkg::FETCH: begin
				if (halted) begin
					stateNext = cpuPkg::HALT; // HLT retired last cycle.
				end else begin
					stateNext = cpuPkg::OPERAND;
				end
			end
			cpuPkg::OPERAND: stateNext = cpuPkg::ACCESS;
			cpuPkg::ACCESS:  stateNext = cpuPkg::EXECUTE;
			cpuPkg::EXECUTE: stateNext = cpuPkg::FETCH;
			cpuPkg::HALT:    stateNext = cpuPkg::HALT;
			default:         stateNext = cpuPkg::IDLE;
		endcase
		if (!run) begin
			stateNext = cpuPkg::IDLE;
		end
	end

	always_ff @(posedge clk or negedge nRst) begin
		if (!nRst) begin
			state   <= cpuPkg::IDLE;
			pc      <= cpuPkg::addr_t'(`CPU_RESET_PC);
			opcode  <= cpuPkg::NOP;
			operand <= '0;
		end else begin
			state <= stateNext;
			if (!run || state == cpuPkg::IDLE) begin
				pc <= cpuPkg::addr_t'(`CPU_RESET_PC);
			end else if (state == cpuPkg::EXECUTE) begin
				pc <= exec.branch ? exec.target : pc + cpuPkg::addr_t'(2);
			end
			if (state == cpuPkg::OPERAND) begin
				opcode <= cpuPkg::opcode_t'(rdata);
			end
			if (state == cpuPkg::ACCESS) begin
				operand <= rdata;
			end
		end
	end

	always_comb begin
		memReq = '0;
		case (state)
			cpuPkg::FETCH:   memReq.addr = pc;
			cpuPkg::OPERAND: memReq.addr = pc + cpuPkg::addr_t'(1);
			cpuPkg::ACCESS: begin
				// Operand byte arrives on rdata this cycle.
				memReq.addr  = (isLoad || isStore) ? rdata : pc;
				memReq.wdata = storeData;
				memReq.we    = isStore;
			end
			default:         memReq.addr = pc;
		endcase
	end

	assign op.opcode  = opcode;
	assign op.operand = operand;
	assign op.valid   = (state == cpuPkg::EXECUTE);

	assign busy = (state != cpuPkg::IDLE);

endmodule

// File: design/cpuExecute.sv
`timescale 1ns/100ps

module cpuExecute (
	input  cpuPkg::decodedOp_t   op,
	input  cpuPkg::byte_t        memData,
	input  cpuPkg::byte_t        accValue,
	input  logic                 zeroFlag,
	output cpuPkg::execResult_t  result
);

	cpuPkg::byte_t aluOut;
	logic          aluWrite;
	logic          takeBranch;
	logic          isHalt;

	always_comb begin
		aluOut     = accValue;
		aluWrite   = 1'b1;
		takeBranch = 1'b0;
		isHalt     = 1'b0;
		case (op.opcode)
			cpuPkg::LDI: aluOut = op.operand;
			cpuPkg::LDA: aluOut = memData;
			cpuPkg::ADD: aluOut = accValue + memData; // Wraps modulo 256.
			cpuPkg::SUB: aluOut = accValue - memData;
			cpuPkg::AND: aluOut = accValue & memData;
			cpuPkg::OR:  aluOut = accValue | memData;
			cpuPkg::XOR: aluOut = accValue ^ memData;
			cpuPkg::JMP: begin
				aluWrite   = 1'b0;
				takeBranch = 1'b1;
			end
			cpuPkg::JZ: begin
				aluWrite   = 1'b0;
				takeBranch = zeroFlag;
			end
			cpuPkg::HLT: begin
				aluWrite = 1'b0;
				isHalt   = 1'b1;
			end
			default: aluWrite = 1'b0; // NOP, STA and undefined codes.
		endcase
	end

	assign result.accNext   = aluOut;
	assign result.writeAcc  = op.valid & aluWrite;
	assign result.writeZero = op.valid & aluWrite;
	assign result.halt      = op.valid & isHalt;
	assign result.branch    = op.valid & takeBranch;
	assign result.target    = op.operand;

endmodule

// File: design/cpuMemory.sv
`timescale 1ns/100ps
`include "cpu_config.svh"

module cpuMemory (
	input  logic             clk,
	input  logic             nRst,
	input  cpuPkg::memReq_t  req,
	output cpuPkg::byte_t    rdata
);

	cpuPkg::byte_t mem [`CPU_MEM_DEPTH];

	// Unified program and data store with a registered read.
	always_ff @(posedge clk or negedge nRst) begin
		if (!nRst) begin
			for (int i = 0; i < `CPU_MEM_DEPTH; i++) begin
				mem[i] <= '0;
			end
			rdata <= '0;
		end else begin
			if (req.we) begin
				mem[req.addr] <= req.wdata;
			end
			rdata <= mem[req.addr]; // Old data on a write.
		end
	end

endmodule

// File: design/cpuPkg.sv
`include "cpu_config.svh"

package cpuPkg;

	typedef logic [`CPU_DATA_WIDTH-1:0] byte_t;
	typedef logic [`CPU_ADDR_WIDTH-1:0] addr_t;

	// Opcode byte of every two-byte instruction.
	typedef enum logic [7:0] {
		NOP = 8'h00,
		LDI = 8'h01,
		LDA = 8'h02,
		STA = 8'h03,
		ADD = 8'h04,
		SUB = 8'h05,
		AND = 8'h06,
		OR  = 8'h07,
		XOR = 8'h08,
		JMP = 8'h09,
		JZ  = 8'h0A,
		HLT = 8'h0F
	} opcode_t;

	typedef enum logic [2:0] {
		IDLE,
		FETCH,
		OPERAND,
		ACCESS,
		EXECUTE,
		HALT
	} decodeState_t;

	typedef struct packed {
		addr_t addr;
		byte_t wdata;
		logic  we;
	} memReq_t;

	typedef struct packed {
		opcode_t opcode;
		byte_t   operand;
		logic    valid; // High in EXECUTE only.
	} decodedOp_t;

	typedef struct packed {
		byte_t accNext;
		logic  writeAcc;
		logic  writeZero; // Zero flag follows accNext.
		logic  halt;
		logic  branch;
		addr_t target;
	} execResult_t;

endpackage

// File: design/cpuResult.sv
`timescale 1ns/100ps

module cpuResult (
	input  logic                 clk,
	input  logic                 nRst,
	input  logic                 run,
	input  cpuPkg::execResult_t  result,
	output cpuPkg::byte_t        acc,
	output logic                 zeroFlag,
	output logic                 halted
);

	// Accumulator and zero flag survive a new run.
	always_ff @(posedge clk or negedge nRst) begin
		if (!nRst) begin
			acc      <= '0;
			zeroFlag <= 1'b0;
		end else if (run) begin
			if (result.writeAcc) begin
				acc <= result.accNext;
			end
			if (result.writeZero) begin
				zeroFlag <= (result.accNext == '0);
			end
		end
	end

	always_ff @(posedge clk or negedge nRst) begin
		if (!nRst) begin
			halted <= 1'b0;
		end else if (!run) begin
			halted <= 1'b0; // Back to idle.
		end else if (result.halt) begin
			halted <= 1'b1;
		end
	end

endmodule

// File: design/cpuTop.sv
`timescale 1ns/100ps

module cpuTop (
	input  logic           clk,
	input  logic           nRst,
	input  logic           run,
	input  logic           loadEn,
	input  cpuPkg::addr_t  loadAddr,
	input  cpuPkg::addr_t  dbgAddr,
	input  cpuPkg::byte_t  loadData,
	output cpuPkg::byte_t  dbgData,
	output cpuPkg::byte_t  acc,
	output logic           halted
);

	cpuPkg::memReq_t      memReq;
	cpuPkg::memReq_t      coreReq;
	cpuPkg::byte_t        memRdata;
	cpuPkg::decodedOp_t   op;
	cpuPkg::execResult_t  execRes;
	cpuPkg::byte_t        accValue;
	logic                 zeroFlag;
	logic                 haltedReg;
	logic                 busy;

	// External port owns the memory only while the core idles.
	always_comb begin
		if (!busy) begin
			memReq.addr  = loadEn ? loadAddr : dbgAddr;
			memReq.wdata = loadData;
			memReq.we    = loadEn;
		end else begin
			memReq = coreReq;
		end
	end

	cpuMemory mem (
		.clk   (clk),
		.nRst  (nRst),
		.req   (memReq),
		.rdata (memRdata)
	);

	cpuDecode decode (
		.clk       (clk),
		.nRst      (nRst),
		.run       (run),
		.rdata     (memRdata),
		.storeData (accValue),
		.halted    (haltedReg),
		.exec      (execRes),
		.memReq    (coreReq),
		.op        (op),
		.busy      (busy)
	);

	cpuExecute execute (
		.op       (op),
		.memData  (memRdata),
		.accValue (accValue),
		.zeroFlag (zeroFlag),
		.result   (execRes)
	);

	cpuResult result (
		.clk      (clk),
		.nRst     (nRst),
		.run      (run),
		.result   (execRes),
		.acc      (accValue),
		.zeroFlag (zeroFlag),
		.halted   (haltedReg)
	);

	assign dbgData = memRdata;
	assign acc     = accValue;
	assign halted  = haltedReg;

endmodule

// File: design/cpu_config.svh
`ifndef CPU_CONFIG_SVH
`define CPU_CONFIG_SVH

// Width of a memory byte and of the accumulator.
`define CPU_DATA_WIDTH 8

// Width of an address and of the program counter.
`define CPU_ADDR_WIDTH 8

`define CPU_MEM_DEPTH 256

`define CPU_RESET_PC 0

`endif

// File: tests/cpuTb.sv
`timescale 1ns/100ps
`include "cpu_config.svh"

module cpuTb;

	logic          clk;
	logic          nRst;
	logic          run;
	logic          loadEn;
	cpuPkg::addr_t loadAddr;
	cpuPkg::addr_t dbgAddr;
	cpuPkg::byte_t loadData;
	cpuPkg::byte_t dbgData;
	cpuPkg::byte_t acc;
	logic          halted;

	// Model state lives for the whole run, like the DUT's.
	cpuPkg::byte_t refMem [`CPU_MEM_DEPTH];
	cpuPkg::byte_t refAcc;
	logic          refZero;

	cpuPkg::opcode_t opPool [10] = '{cpuPkg::LDI, cpuPkg::LDA, cpuPkg::STA, cpuPkg::ADD,
		cpuPkg::SUB, cpuPkg::AND, cpuPkg::OR, cpuPkg::XOR, cpuPkg::JMP, cpuPkg::JZ};

	int errCount;
	int testErrStart;
	int testsRun;
	int testsFailed;
	bit timedOut;

	cpuTop uut (
		.clk      (clk),
		.nRst     (nRst),
		.run      (run),
		.loadEn   (loadEn),
		.loadAddr (loadAddr),
		.dbgAddr  (dbgAddr),
		.loadData (loadData),
		.dbgData  (dbgData),
		.acc      (acc),
		.halted   (halted)
	);

	always #10 clk = ~clk;

	task automatic tick();
		@(posedge clk);
		#2;
	endtask

	task automatic writeByte(input cpuPkg::addr_t a, input cpuPkg::byte_t d);
		loadEn   = 1'b1;
		loadAddr = a;
		loadData = d;
		tick();
		loadEn    = 1'b0;
		refMem[a] = d;
	endtask

	task automatic checkByte(input cpuPkg::addr_t a, input cpuPkg::byte_t exp);
		cpuPkg::byte_t got;
		dbgAddr = a;
		tick();
		got = dbgData; // Read registered at the last edge.
		assert (got == exp) else begin
			errCount++;
			$display("error: dbgData at %h is %h, expected %h", a, got, exp);
		end
	endtask

	task automatic waitHalted();
		int cycles;
		cycles = 0;
		while (!halted && cycles < 2000) begin
			tick();
			cycles++;
		end
		if (!halted) begin
			errCount++;
			timedOut = 1'b1;
			$display("halted did not rise within 2000 cycles");
		end
	endtask

	// Instruction-set interpreter over the model memory.
	task automatic runModel();
		cpuPkg::addr_t   pc;
		cpuPkg::opcode_t opc;
		cpuPkg::byte_t   arg;
		bit              done;
		int              steps;
		pc    = cpuPkg::addr_t'(`CPU_RESET_PC);
		done  = 1'b0;
		steps = 0;
		while (!done && steps < 1000) begin
			opc   = cpuPkg::opcode_t'(refMem[pc]);
			arg   = refMem[cpuPkg::addr_t'(pc + 8'd1)];
			pc    = pc + 8'd2;
			steps = steps + 1;
			case (opc)
				cpuPkg::LDI: refAcc = arg;
				cpuPkg::LDA: refAcc = refMem[arg];
				cpuPkg::STA: refMem[arg] = refAcc;
				cpuPkg::ADD: refAcc = refAcc + refMem[arg];
				cpuPkg::SUB: refAcc = refAcc - refMem[arg];
				cpuPkg::AND: refAcc = refAcc & refMem[arg];
				cpuPkg::OR:  refAcc = refAcc | refMem[arg];
				cpuPkg::XOR: refAcc = refAcc ^ refMem[arg];
				cpuPkg::JMP: pc = arg;
				cpuPkg::JZ:  pc = refZero ? arg : pc;
				cpuPkg::HLT: done = 1'b1;
				default:     done = 1'b0; // Undefined codes act as NOP.
			endcase
			if (opc inside {cpuPkg::LDI, cpuPkg::LDA, cpuPkg::ADD, cpuPkg::SUB,
					cpuPkg::AND, cpuPkg::OR, cpuPkg::XOR}) begin
				refZero = (refAcc == 8'h00);
			end
		end
	endtask

	task automatic genProgram(input bit withBranches);
		int              n;
		int              t;
		cpuPkg::opcode_t opc;
		cpuPkg::byte_t   arg;
		for (int i = 0; i < 16; i++) begin
			writeByte(cpuPkg::addr_t'($urandom) | 8'h80, cpuPkg::byte_t'($urandom));
		end
		n = 6 + int'($urandom % 15);
		for (int i = 0; i < n; i++) begin
			arg = cpuPkg::byte_t'($urandom);
			if (i == n - 1) begin
				opc = cpuPkg::HLT;
			end else begin
				opc = opPool[withBranches ? $urandom % 10 : $urandom % 8];
			end
			if (opc == cpuPkg::JMP || opc == cpuPkg::JZ) begin
				t   = i + 1 + int'($urandom % (n - 1 - i)); // Ahead, at most the HLT.
				arg = cpuPkg::byte_t'(2 * t);
			end else if (opc == cpuPkg::LDI) begin
				if ($urandom % 4 == 0) begin
					arg = 8'h00; // Gives JZ something to take.
				end
			end else if (opc != cpuPkg::HLT) begin
				arg = arg | 8'h80; // Data area.
			end
			writeByte(cpuPkg::addr_t'(2 * i), opc);
			writeByte(cpuPkg::addr_t'(2 * i + 1), arg);
		end
	endtask

	task automatic runProgram();
		if (timedOut) begin
			return;
		end
		run = 1'b1;
		waitHalted();
		if (timedOut) begin
			return;
		end
		runModel();
		assert (acc == refAcc) else begin
			errCount++;
			$display("error: acc is %h, expected %h", acc, refAcc);
		end
		run = 1'b0;
		tick();
		for (int a = 8'h80; a < `CPU_MEM_DEPTH; a++) begin
			checkByte(cpuPkg::addr_t'(a), refMem[cpuPkg::addr_t'(a)]);
		end
	endtask

	task automatic endTest(input string name);
		testsRun++;
		if (errCount == testErrStart) begin
			$display("test %0d %s: ok", testsRun, name);
		end else begin
			testsFailed++;
			$display("test %0d %s: failed, %0d errors", testsRun, name,
				errCount - testErrStart);
		end
		testErrStart = errCount;
	endtask

	task automatic endRun();
		$display("tests run %0d, failed %0d, errors %0d", testsRun, testsFailed, errCount);
		if (errCount == 0) begin
			$display("PASS: all tests");
		end else begin
			$display("FAIL: see errors above");
		end
		$finish;
	endtask

	initial begin
		cpuPkg::addr_t a;
		cpuPkg::addr_t written [$];
		void'($urandom(32'h20b6_cac7));
		clk          = 1'b0;
		nRst         = 1'b0;
		run          = 1'b0;
		loadEn       = 1'b0;
		loadAddr     = '0;
		dbgAddr      = '0;
		loadData     = '0;
		errCount     = 0;
		testErrStart = 0;
		testsRun     = 0;
		testsFailed  = 0;
		timedOut     = 1'b0;
		refAcc       = '0;
		refZero      = 1'b0;
		for (int i = 0; i < `CPU_MEM_DEPTH; i++) begin
			refMem[i] = '0;
		end
		repeat (5) @(posedge clk);
		#2;
		nRst = 1'b1;
		tick();

		assert (halted == 1'b0) else begin
			errCount++;
			$display("error: halted is %h, expected 0", halted);
		end
		assert (acc == 8'h00) else begin
			errCount++;
			$display("error: acc is %h, expected 00", acc);
		end
		for (int i = 0; i < 16; i++) begin
			checkByte(cpuPkg::addr_t'($urandom), 8'h00);
		end
		endTest("reset state");

		for (int i = 0; i < 96; i++) begin
			a = cpuPkg::addr_t'($urandom);
			writeByte(a, cpuPkg::byte_t'($urandom));
			written.push_back(a);
		end
		foreach (written[i]) begin
			checkByte(written[i], refMem[written[i]]);
		end
		endTest("load and readback");

		for (int p = 0; p < 8; p++) begin
			genProgram(1'b0);
			runProgram();
		end
		endTest("straight-line programs");

		for (int p = 0; p < 8; p++) begin
			genProgram(1'b1);
			runProgram();
		end
		endTest("forward branches");

		for (int p = 0; p < 4; p++) begin
			genProgram(1'b1);
			runProgram();
			runProgram(); // Same program on the memory it left.
		end
		endTest("rerun");

		endRun();
	end

endmodule

// File: tests/cpuTop_sva.sv
`timescale 1ns/100ps

module cpuTop_sva (
	input logic                clk,
	input logic                nRst,
	input logic                run,
	input logic                busy,
	input logic                halted,
	input cpuPkg::byte_t       acc,
	input cpuPkg::memReq_t     memReq,
	input cpuPkg::decodedOp_t  op
);

	haltedAfterReset: assert property (@(posedge clk) $rose(nRst) |-> !halted)
		else $error("halted high in the first cycle after reset");

	accHeldWhileHalted: assert property (@(posedge clk) disable iff (!nRst)
		halted |=> $stable(acc))
		else $error("acc changed while halted");

	haltedNeedsRun: assert property (@(posedge clk) disable iff (!nRst)
		!run |=> !halted)
		else $error("halted high after run was low");

	// Core writes only in the ACCESS cycle of a STA.
	writeOnlyOnStore: assert property (@(posedge clk) disable iff (!nRst)
		busy && run && memReq.we |=> op.valid && op.opcode == cpuPkg::STA)
		else $error("memory write while busy outside a STA access");

endmodule

bind cpuTop cpuTop_sva sva (
	.clk    (clk),
	.nRst   (nRst),
	.run    (run),
	.busy   (busy),
	.halted (halted),
	.acc    (acc),
	.memReq (memReq),
	.op     (op)
);
